// ==== design/usb_hub_pkg.sv ====
// Shared types and default timing for the hub downstream ports.
// Timing constants are in clock cycles and assume a 48 MHz port clock.
`default_nettype none

package usb_hub_pkg;

    // Port state encoding, same values as the hub status word
    typedef enum logic [1:0] {
        DISABLED  = 2'd0,
        RESETTING = 2'd1,
        ENABLED   = 2'd2,
        SUSPENDED = 2'd3
    } port_state_e;

    // Downstream line state, raw or synchronized
    typedef struct packed {
        logic j;
        logic k;
        logic se0;
    } line_state_t;

    // Sticky change bits, also the layout of the host clear strobes
    typedef struct packed {
        logic connect;
        logic enable;
        logic suspend;
    } port_change_t;

    // Per-port status as reported to the hub controller
    typedef struct packed {
        port_state_e state;
        logic        powered;
        logic        enabled;
        logic        lowspeed;
    } port_status_t;

    // About 10 ms of port reset at 48 MHz would need a larger value;
    // this default keeps simulation short
    localparam int unsigned DEFAULT_RESET_CYCLES    = 5000;

    // Identical connect samples needed before the level is accepted
    localparam int unsigned DEFAULT_DEBOUNCE_CYCLES = 8;

endpackage

`default_nettype wire

// ==== design/hub_line_sync.sv ====
// Two-flop synchronizer for the downstream line state and connect detect.
// DEBOUNCE_CYCLES must be at least 1; glitches shorter than that are ignored.
`default_nettype none
`timescale 1ns/1ps

module hub_line_sync
    import usb_hub_pkg::*;
#(
    parameter int unsigned DEBOUNCE_CYCLES = DEFAULT_DEBOUNCE_CYCLES
) (
    input  wire         clk_i,
    input  wire         rst_n_i,
    input  line_state_t line_i,
    input  wire         connected_i,
    output line_state_t line_o,
    output logic        connected_o
);

    localparam int unsigned CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    line_state_t      line_meta;
    line_state_t      line_sync;
    logic             conn_meta;
    logic             conn_sync;
    logic [CNT_W-1:0] deb_cnt;
    logic             conn_q;

    // Metastability flops for all asynchronous inputs
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            line_meta <= '0;
            line_sync <= '0;
            conn_meta <= 1'b0;
            conn_sync <= 1'b0;
        end else begin
            line_meta <= line_i;
            line_sync <= line_meta;
            conn_meta <= connected_i;
            conn_sync <= conn_meta;
        end
    end

    // Counter restarts whenever the synchronized level matches the output
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            deb_cnt <= '0;
            conn_q  <= 1'b0;
        end else if (conn_sync == conn_q) begin
            deb_cnt <= '0;
        end else if (deb_cnt == CNT_LAST) begin
            // Enough identical samples seen
            conn_q  <= conn_sync;
            deb_cnt <= '0;
        end else begin
            deb_cnt <= deb_cnt + CNT_W'(1);
        end
    end

    assign line_o      = line_sync;
    assign connected_o = conn_q;

endmodule

`default_nettype wire

// ==== design/hub_port_fsm.sv ====
// Port state machine for one downstream port, no high-speed chirp support.
// connected_i and line_i must already be synchronized to clk_i.
`default_nettype none
`timescale 1ns/1ps

module hub_port_fsm
    import usb_hub_pkg::*;
#(
    parameter int unsigned RESET_CYCLES = DEFAULT_RESET_CYCLES
) (
    input  wire          clk_i,
    input  wire          rst_n_i,
    input  wire          connected_i,
    input  line_state_t  line_i,
    input  wire          reset_req_i,
    input  wire          suspend_req_i,
    input  port_change_t clear_change_i,
    output port_status_t status_o,
    output port_change_t change_o
);

    localparam int unsigned CNT_W = (RESET_CYCLES > 1) ? $clog2(RESET_CYCLES) : 1;
    localparam logic [CNT_W-1:0] RST_LAST = CNT_W'(RESET_CYCLES - 1);

    port_status_t     status_q;
    port_status_t     status_d;
    port_change_t     change_q;
    port_change_t     change_d;
    port_change_t     change_set;
    logic [CNT_W-1:0] rst_cnt_q;
    logic [CNT_W-1:0] rst_cnt_d;
    logic             conn_q;
    logic             conn_rise;
    logic             conn_fall;

    // Edges of the debounced connect level
    assign conn_rise = connected_i & ~conn_q;
    assign conn_fall = ~connected_i & conn_q;

    always_comb begin
        status_d   = status_q;
        rst_cnt_d  = rst_cnt_q;
        change_set = '0;

        if (conn_fall) begin
            // Disconnect overrides whatever the port was doing
            status_d.state   = DISABLED;
            status_d.powered = 1'b0;
            status_d.enabled = 1'b0;
            change_set.connect = 1'b1;
        end else begin
            if (conn_rise) begin
                status_d.powered   = 1'b1;
                change_set.connect = 1'b1;
            end

            unique case (status_q.state)
                DISABLED: begin
                    if (connected_i) begin
                        // Low-speed devices idle with K on the bus
                        status_d.lowspeed = line_i.k;
                        if (reset_req_i) begin
                            status_d.state = RESETTING;
                            rst_cnt_d      = '0;
                        end
                    end
                end

                RESETTING: begin
                    if (rst_cnt_q == RST_LAST) begin
                        status_d.state    = ENABLED;
                        status_d.enabled  = 1'b1;
                        change_set.enable = 1'b1;
                    end else begin
                        rst_cnt_d = rst_cnt_q + CNT_W'(1);
                    end
                end

                ENABLED: begin
                    if (suspend_req_i) begin
                        status_d.state = SUSPENDED;
                    end
                end

                SUSPENDED: begin
                    // Host resume, or remote wakeup signalled as K
                    if (!suspend_req_i || line_i.k) begin
                        status_d.state     = ENABLED;
                        change_set.suspend = 1'b1;
                    end
                end

                default: begin
                    status_d.state = DISABLED;
                end
            endcase
        end

        // A new event beats a clear in the same cycle
        change_d = (change_q & ~clear_change_i) | change_set;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            status_q  <= '{state: DISABLED, powered: 1'b0, enabled: 1'b0, lowspeed: 1'b0};
            change_q  <= '0;
            rst_cnt_q <= '0;
            conn_q    <= 1'b0;
        end else begin
            status_q  <= status_d;
            change_q  <= change_d;
            rst_cnt_q <= rst_cnt_d;
            conn_q    <= connected_i;
        end
    end

    assign status_o = status_q;
    assign change_o = change_q;

endmodule

`default_nettype wire

// ==== design/hub_change_bitmap.sv ====
// Builds the hub status-change bitmap, one bit per downstream port.
// change_irq_o pulses only when the bitmap leaves the all-zero state.
`default_nettype none
`timescale 1ns/1ps

module hub_change_bitmap
    import usb_hub_pkg::*;
#(
    parameter int unsigned NUM_PORTS = 4
) (
    input  wire                                clk_i,
    input  wire                                rst_n_i,
    input  port_change_t [NUM_PORTS-1:0]       port_change_i,
    output logic         [NUM_PORTS-1:0]       change_bitmap_o,
    output logic                               change_irq_o
);

    logic [NUM_PORTS-1:0] bitmap_d;
    logic [NUM_PORTS-1:0] bitmap_q;
    logic                 bitmap_was_empty;
    logic                 irq_q;

    // Any pending change on a port marks its bit
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            bitmap_d[p] = |port_change_i[p];
        end
    end

    assign bitmap_was_empty = ~|bitmap_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bitmap_q <= '0;
            irq_q    <= 1'b0;
        end else begin
            bitmap_q <= bitmap_d;
            // Lines up with the first non-zero registered bitmap
            irq_q    <= bitmap_was_empty & (|bitmap_d);
        end
    end

    assign change_bitmap_o = bitmap_q;
    assign change_irq_o    = irq_q;

endmodule

`default_nettype wire

// ==== design/usb_hub_ports.sv ====
// Downstream port block of a USB hub with NUM_PORTS identical ports.
// Line and connect inputs may be asynchronous; hub controls must be synchronous.
`default_nettype none
`timescale 1ns/1ps

module usb_hub_ports
    import usb_hub_pkg::*;
#(
    parameter int unsigned NUM_PORTS       = 4,
    parameter int unsigned RESET_CYCLES    = DEFAULT_RESET_CYCLES,
    parameter int unsigned DEBOUNCE_CYCLES = DEFAULT_DEBOUNCE_CYCLES
) (
    input  wire                          clk_i,
    input  wire                          rst_n_i,
    input  wire          [NUM_PORTS-1:0] port_connected_i,
    input  wire          [NUM_PORTS-1:0] port_reset_i,
    input  wire          [NUM_PORTS-1:0] port_suspend_i,
    input  line_state_t  [NUM_PORTS-1:0] line_i,
    input  port_change_t [NUM_PORTS-1:0] clear_change_i,
    output port_status_t [NUM_PORTS-1:0] port_status_o,
    output port_change_t [NUM_PORTS-1:0] port_change_o,
    output logic         [NUM_PORTS-1:0] change_bitmap_o,
    output logic                         change_irq_o
);

    // Synchronized line state and debounced connect per port
    line_state_t [NUM_PORTS-1:0] sync_line;
    logic        [NUM_PORTS-1:0] sync_conn;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        hub_line_sync #(
            .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
        ) u_sync (
            .clk_i      (clk_i),
            .rst_n_i    (rst_n_i),
            .line_i     (line_i[p]),
            .connected_i(port_connected_i[p]),
            .line_o     (sync_line[p]),
            .connected_o(sync_conn[p])
        );

        hub_port_fsm #(
            .RESET_CYCLES(RESET_CYCLES)
        ) u_fsm (
            .clk_i         (clk_i),
            .rst_n_i       (rst_n_i),
            .connected_i   (sync_conn[p]),
            .line_i        (sync_line[p]),
            .reset_req_i   (port_reset_i[p]),
            .suspend_req_i (port_suspend_i[p]),
            .clear_change_i(clear_change_i[p]),
            .status_o      (port_status_o[p]),
            .change_o      (port_change_o[p])
        );
    end

    hub_change_bitmap #(
        .NUM_PORTS(NUM_PORTS)
    ) u_bitmap (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .port_change_i  (port_change_o),
        .change_bitmap_o(change_bitmap_o),
        .change_irq_o   (change_irq_o)
    );

endmodule

`default_nettype wire

// ==== testbench/hub_ref_model.svh ====
// Reference rules for one hub port, evaluated once per clock edge.
// Inputs are the synchronized and debounced values that the port sees.
`ifndef HUB_REF_MODEL_SVH
`define HUB_REF_MODEL_SVH

// Next status of a port from its current status and this cycle's inputs
function automatic port_status_t next_status(port_status_t s, logic conn, logic conn_prev,
                                             line_state_t ln, logic rst_req, logic susp_req,
                                             logic reset_done);
    port_status_t n;
    n = s;
    // Disconnect wins over every other event
    if (!conn && conn_prev) begin
        n.state   = DISABLED;
        n.powered = 1'b0;
        n.enabled = 1'b0;
        return n;
    end
    if (conn && !conn_prev) begin
        n.powered = 1'b1;
    end
    case (s.state)
        DISABLED: begin
            if (conn) begin
                n.lowspeed = ln.k;
                if (rst_req) begin
                    n.state = RESETTING;
                end
            end
        end
        RESETTING: begin
            if (reset_done) begin
                n.state   = ENABLED;
                n.enabled = 1'b1;
            end
        end
        ENABLED: begin
            if (susp_req) begin
                n.state = SUSPENDED;
            end
        end
        default: begin
            if (!susp_req || ln.k) begin
                n.state = ENABLED;
            end
        end
    endcase
    return n;
endfunction

// Sticky change bits after this cycle's events and clear strobes
function automatic port_change_t next_change(port_change_t c, port_change_t clr,
                                             port_status_t s, logic conn, logic conn_prev,
                                             line_state_t ln, logic susp_req, logic reset_done);
    port_change_t set_bits;
    set_bits = '0;
    if (conn != conn_prev) begin
        set_bits.connect = 1'b1;
    end
    if (!(!conn && conn_prev)) begin
        if (s.state == RESETTING && reset_done) begin
            set_bits.enable = 1'b1;
        end
        if (s.state == SUSPENDED && (!susp_req || ln.k)) begin
            set_bits.suspend = 1'b1;
        end
    end
    // Set beats clear
    return (c & ~clr) | set_bits;
endfunction

`endif

// ==== testbench/tb_usb_hub_ports.sv ====
// Testbench for usb_hub_ports with 4 ports, a short reset and debounce.
// A cycle model runs beside the DUT and every output is compared each cycle.
`default_nettype none
`timescale 1ns/1ps

module tb_usb_hub_ports
    import usb_hub_pkg::*;
;
    localparam int NP        = 4;
    localparam int RST_CYC   = 20;
    localparam int DEB_CYC   = 6;
    localparam int NUM_SCEN  = 8;
    localparam int LIMIT     = NUM_SCEN * (RST_CYC + DEB_CYC + 40);

    `include "hub_ref_model.svh"

    logic                  clk_i = 1'b0;
    logic                  rst_n_i;
    logic         [NP-1:0] conn;
    logic         [NP-1:0] rst_req;
    logic         [NP-1:0] susp;
    line_state_t  [NP-1:0] line;
    port_change_t [NP-1:0] clr;
    port_status_t [NP-1:0] status;
    port_change_t [NP-1:0] change;
    logic         [NP-1:0] bitmap;
    logic                  irq;

    // Model state
    line_state_t  m_ls1 [NP];
    line_state_t  m_ls2 [NP];
    logic         m_cs1 [NP];
    logic         m_cs2 [NP];
    logic         m_deb [NP];
    logic         m_cprev [NP];
    int           m_run [NP];
    int           m_rcnt [NP];
    port_status_t m_st [NP];
    port_change_t m_chg [NP];
    logic [NP-1:0] m_bm;
    logic          m_irq;

    int     errors;
    int     cycles;
    integer seed;

    usb_hub_ports #(
        .NUM_PORTS(NP),
        .RESET_CYCLES(RST_CYC),
        .DEBOUNCE_CYCLES(DEB_CYC)
    ) uut (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .port_connected_i(conn),
        .port_reset_i    (rst_req),
        .port_suspend_i  (susp),
        .line_i          (line),
        .clear_change_i  (clr),
        .port_status_o   (status),
        .port_change_o   (change),
        .change_bitmap_o (bitmap),
        .change_irq_o    (irq)
    );

    initial begin
        forever #10 clk_i = ~clk_i;
    end

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    // Model update from the values seen before this edge
    always @(posedge clk_i) begin : ref_update
        logic [NP-1:0] bm_d;
        logic          done;
        for (int p = 0; p < NP; p++) begin
            bm_d[p] = |m_chg[p];
        end
        if (!rst_n_i) begin
            for (int p = 0; p < NP; p++) begin
                m_ls1[p] = '0;
                m_ls2[p] = '0;
                m_cs1[p] = 1'b0;
                m_cs2[p] = 1'b0;
                m_deb[p] = 1'b0;
                m_cprev[p] = 1'b0;
                m_run[p] = 0;
                m_rcnt[p] = 0;
                m_st[p] = '{state: DISABLED, powered: 1'b0, enabled: 1'b0, lowspeed: 1'b0};
                m_chg[p] = '0;
            end
            m_bm  = '0;
            m_irq = 1'b0;
        end else begin
            m_irq = (m_bm == '0) && (bm_d != '0);
            m_bm  = bm_d;
            for (int p = 0; p < NP; p++) begin
                done = (m_st[p].state == RESETTING) && (m_rcnt[p] == RST_CYC - 1);
                m_chg[p] = next_change(m_chg[p], clr[p], m_st[p], m_deb[p], m_cprev[p],
                                       m_ls2[p], susp[p], done);
                if (m_st[p].state == DISABLED) begin
                    m_rcnt[p] = 0;
                end else if (m_st[p].state == RESETTING) begin
                    m_rcnt[p] = m_rcnt[p] + 1;
                end
                m_st[p] = next_status(m_st[p], m_deb[p], m_cprev[p], m_ls2[p], rst_req[p],
                                      susp[p], done);
                m_cprev[p] = m_deb[p];
                // Debounce on the synchronized connect level
                if (m_cs2[p] == m_deb[p]) begin
                    m_run[p] = 0;
                end else if (m_run[p] == DEB_CYC - 1) begin
                    m_deb[p] = m_cs2[p];
                    m_run[p] = 0;
                end else begin
                    m_run[p] = m_run[p] + 1;
                end
                m_ls2[p] = m_ls1[p];
                m_ls1[p] = line[p];
                m_cs2[p] = m_cs1[p];
                m_cs1[p] = conn[p];
            end
        end
    end

    // Registered outputs are compared on the falling edge
    always @(negedge clk_i) begin
        for (int p = 0; p < NP; p++) begin
            check_value($sformatf("port_status_o[%0d]", p), 32'(status[p]), 32'(m_st[p]));
            check_value($sformatf("port_change_o[%0d]", p), 32'(change[p]), 32'(m_chg[p]));
        end
        check_value("change_bitmap_o", 32'(bitmap), 32'(m_bm));
        check_value("change_irq_o", 32'(irq), 32'(m_irq));
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Run timed out after %0d cycles with %0d errors", cycles, errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic idle(int n);
        repeat (n) @(negedge clk_i);
    endtask

    task automatic wait_for_state(int p, port_state_e s, int max_cycles);
        int n;
        n = 0;
        while (status[p].state != s && n < max_cycles) begin
            @(negedge clk_i);
            n++;
        end
        if (status[p].state != s) begin
            errors++;
            $display("Port %0d did not reach state %s within %0d cycles", p, s.name(), n);
        end
    endtask

    task automatic reset_port(int p);
        int n;
        n = 0;
        @(negedge clk_i);
        rst_req[p] = 1'b1;
        @(negedge clk_i);
        rst_req[p] = 1'b0;
        // Count the cycles spent in RESETTING
        while (status[p].state == RESETTING && n < 2 * RST_CYC) begin
            n++;
            @(negedge clk_i);
        end
        check_value($sformatf("port %0d reset length", p), n, RST_CYC);
        wait_for_state(p, ENABLED, 4);
    endtask

    initial begin
        errors  = 0;
        cycles  = 0;
        seed    = 32'h31c9;
        rst_n_i = 1'b0;
        conn    = '0;
        rst_req = '0;
        susp    = '0;
        clr     = '0;
        for (int p = 0; p < NP; p++) begin
            line[p] = '{j: 1'b1, k: 1'b0, se0: 1'b0};
        end
        idle(5);
        rst_n_i = 1'b1;
        idle(3);

        // Short connect glitch on port 3
        conn[3] = 1'b1;
        idle(3);
        conn[3] = 1'b0;
        idle(DEB_CYC + 4);
        // Ports 0 to 2 connect and port 1 idles with K
        line[1] = '{j: 1'b0, k: 1'b1, se0: 1'b0};
        conn[2:0] = 3'b111;
        idle(DEB_CYC + 4);

        reset_port(0);
        reset_port(1);
        reset_port(2);

        // Suspend and host resume on port 0
        susp[0] = 1'b1;
        wait_for_state(0, SUSPENDED, 4);
        susp[0] = 1'b0;
        wait_for_state(0, ENABLED, 4);
        // Suspend again and wake up with K on the line
        susp[0] = 1'b1;
        wait_for_state(0, SUSPENDED, 4);
        idle(2);
        line[0] = '{j: 1'b0, k: 1'b1, se0: 1'b0};
        wait_for_state(0, ENABLED, 6);
        line[0] = '{j: 1'b1, k: 1'b0, se0: 1'b0};
        susp[0] = 1'b0;
        susp[2] = 1'b1;
        wait_for_state(2, SUSPENDED, 4);

        // Clear everything and then disconnect while port 2 holds its connect clear
        clr = '1;
        idle(1);
        clr = '0;
        idle(2);
        conn[2:0] = 3'b000;
        clr[2].connect = 1'b1;
        idle(DEB_CYC + 6);
        clr[2].connect = 1'b0;
        susp[2] = 1'b0;
        idle(2);

        // Random connects, controls and clear strobes
        for (int i = 0; i < 120; i++) begin
            for (int p = 0; p < NP; p++) begin
                if (($random(seed) & 15) == 0) conn[p] = ~conn[p];
                if (($random(seed) & 7) == 0) line[p].k = ~line[p].k;
                rst_req[p] = (($random(seed) & 7) == 0);
                if (($random(seed) & 15) == 0) susp[p] = ~susp[p];
                clr[p] = (($random(seed) & 3) == 0) ? port_change_t'($random(seed)) : '0;
            end
            idle(1);
        end
        clr = '0;
        idle(4);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+testbench
design/usb_hub_pkg.sv
design/hub_line_sync.sv
design/hub_port_fsm.sv
design/hub_change_bitmap.sv
design/usb_hub_ports.sv
testbench/tb_usb_hub_ports.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the hub port testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_usb_hub_ports -f src.f -o sim_tb \
    > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "TESTS PASSED" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }
